// File: dv/hk_stimulus.txt
# op adr wdat expected tol (hex except tol); r read, w write (expected = ctrl_o after it)
# m monitor read within tol, s serial reads (wdat = count, expected = 64-bit id), i idle cycles
r 000 00000000 484B494F 0
r 004 00000000 01040211 0
r 010 00000000 484B494F 0
r 014 00000000 01040211 0
r 030 00000000 484B494F 0
r 034 00000000 01040211 0
w 000 DEADBEEF 00000000 0
w 014 12345678 00000000 0
r 000 00000000 484B494F 0
r 004 00000000 01040211 0
w 008 80000000 00000000 0
s 008 00000040 5A3C0F961E2D4B87 0
i 000 00000320 00000000 0
m 040 00000000 00000100 2
m 044 00000000 00000100 2
m 048 00000000 00000100 2
m 04C 00000000 00000200 2
m 050 00000000 00000199 2
r 054 00000000 00000000 0
w 00C 0000A5C3 0000A5C3 0
r 00C 00000000 001FA5C3 0
w 01C 00001234 00001234 0
r 02C 00000000 001F1234 0
w 00C FFFF0000 00000000 0
r 00C 00000000 001F0000 0
r 03C 00000000 001F0000 0
r 080 00000000 00000000 0
r FFC 00000000 00000000 0
w FFC 0000BEEF 00000000 0

// File: all.f
common/hk_pkg.sv
common/hk_req_if.sv
clock_mon/clock_count_cell.sv
clock_mon/clock_mon.sv
logic/hk_bus_decode.sv
logic/hk_id_regs.sv
logic/hk_top.sv
dv/hk_assert.sv
dv/hk_tb.sv

// File: Bender.yml
package:
  name: hk

sources:
  - files:
      - common/hk_pkg.sv
      - common/hk_req_if.sv
      - clock_mon/clock_count_cell.sv
      - clock_mon/clock_mon.sv
      - logic/hk_bus_decode.sv
      - logic/hk_id_regs.sv
      - logic/hk_top.sv
  - target: test
    files:
      - dv/hk_assert.sv
      - dv/hk_tb.sv

// File: dv/hk_tb.sv
`timescale 1ns/1ps

// Testbench for the housekeeping register block
// Operations and expected values come from dv/hk_stimulus.txt
module hk_tb;

    logic clk_i;
    logic rst_i;
    logic cyc_i;
    logic stb_i;
    logic we_i;
    logic [hk_pkg::ADR_W-1:0] adr_i;
    hk_pkg::hk_word_t dat_i;
    logic ack_o;
    hk_pkg::hk_word_t dat_o;
    logic [hk_pkg::CTRL_W-1:0] ctrl_o;

    // Monitored clocks
    logic sys_clk;
    logic gtp_clk;
    logic rx_clk;
    logic rx_clk_x2;
    logic clk200;

    // Stimulus table with one entry per file line
    byte ops_q[$];
    logic [hk_pkg::ADR_W-1:0] adrs_q[$];
    hk_pkg::hk_word_t wdats_q[$];
    logic [63:0] exps_q[$];
    int tols_q[$];

    int cycle_cnt;
    int cycle_limit;

    hk_top u_hk_top (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .we_i        (we_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .ack_o       (ack_o),
        .dat_o       (dat_o),
        .sys_clk_i   (sys_clk),
        .gtp_clk_i   (gtp_clk),
        .rx_clk_i    (rx_clk),
        .rx_clk_x2_i (rx_clk_x2),
        .clk200_i    (clk200),
        .ctrl_o      (ctrl_o)
    );

    // 8 ns bus clock
    always #4 clk_i = ~clk_i;

    // Monitored periods of 8, 8, 8, 4 and 5 ns
    // The 8 ns clocks rise on bus clock falling edges
    always #4 sys_clk = ~sys_clk;
    always #4 gtp_clk = ~gtp_clk;
    always #4 rx_clk = ~rx_clk;
    always #2 rx_clk_x2 = ~rx_clk_x2;
    always #2.5 clk200 = ~clk200;

    // Watchdog on total run length
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: no bus acknowledge");
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic report_failure(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    // Bound handshake checker keeps a tally of its failed assertions
    always @(negedge clk_i) begin
        if (u_hk_top.u_hk_assert.fail_count != 0) begin
            report_failure("handshake assertion failed");
        end
    end

    task automatic check_word(input hk_pkg::hk_word_t got, input hk_pkg::hk_word_t exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s got %08h expected %08h", what, got, exp));
        end
    endtask

    // Monitor counts drift with clock phase so they get a window of +-tol
    task automatic check_count(input hk_pkg::hk_word_t got, input hk_pkg::hk_word_t exp,
                               input int tol, input string what);
        int diff;
        diff = int'(got) - int'(exp);
        if ($isunknown(got) || diff < -tol || diff > tol) begin
            report_failure($sformatf("%s got %0d expected %0d +-%0d", what, got, exp, tol));
        end
    endtask

    task automatic check_ctrl(input logic [hk_pkg::CTRL_W-1:0] got,
                              input logic [hk_pkg::CTRL_W-1:0] exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s ctrl_o %04h expected %04h", what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("%s took %0d cycles, expected %0d", what, got, exp));
        end
    endtask

    // One Wishbone access
    // Cycles are counted from the edge that first sees stb
    task automatic bus_access(input logic we, input logic [hk_pkg::ADR_W-1:0] adr,
                              input hk_pkg::hk_word_t wdat, output hk_pkg::hk_word_t rdat);
        int waited;
        @(posedge clk_i);
        cyc_i <= 1'b1;
        stb_i <= 1'b1;
        we_i  <= we;
        adr_i <= adr;
        dat_i <= wdat;
        @(posedge clk_i);
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (ack_o !== 1'b1);
        rdat = dat_o;
        check_latency(waited, 3, $sformatf("ack for %03h", adr));
        // Drop the strobe on the edge after ack
        @(posedge clk_i);
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    task automatic load_stimulus(output int n_access);
        int fd;
        int n;
        string line;
        byte op;
        logic [hk_pkg::ADR_W-1:0] adr;
        hk_pkg::hk_word_t wdat;
        logic [63:0] exp;
        int tol;
        n_access = 0;
        fd = $fopen("dv/hk_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file dv/hk_stimulus.txt");
            $display("TB FAILED");
            $fatal(1, "no stimulus");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#" && line[0] != "\n") begin
                    n = $sscanf(line, "%c %h %h %h %d", op, adr, wdat, exp, tol);
                    if (n != 5 || !(op inside {"r", "w", "m", "s", "i"})) begin
                        $display("stimulus line not understood: %s", line);
                        $display("TB FAILED");
                        $fatal(1, "bad stimulus");
                    end else begin
                        ops_q.push_back(op);
                        adrs_q.push_back(adr);
                        wdats_q.push_back(wdat);
                        exps_q.push_back(exp);
                        tols_q.push_back(tol);
                        // Serial lines expand into one read per bit
                        if (op == "s") begin
                            n_access += int'(wdat);
                        end else if (op != "i") begin
                            n_access += 1;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_operation(input int k);
        hk_pkg::hk_word_t rdat;
        logic [hk_pkg::ADR_W-1:0] adr;
        adr = adrs_q[k];
        case (ops_q[k])
            "r": begin
                bus_access(1'b0, adr, '0, rdat);
                check_word(rdat, exps_q[k][31:0], $sformatf("read %03h", adr));
            end
            "w": begin
                // Expected column holds ctrl_o after the write
                bus_access(1'b1, adr, wdats_q[k], rdat);
                check_ctrl(ctrl_o, exps_q[k][hk_pkg::CTRL_W-1:0], $sformatf("write %03h", adr));
            end
            "m": begin
                bus_access(1'b0, adr, '0, rdat);
                check_count(rdat, exps_q[k][31:0], tols_q[k], $sformatf("monitor %03h", adr));
            end
            "s": begin
                // Serial number comes out LSB first with one bit per read
                for (int b = 0; b < int'(wdats_q[k]); b++) begin
                    bus_access(1'b0, adr, '0, rdat);
                    check_word(rdat, {31'b0, exps_q[k][b]}, $sformatf("serial bit %0d", b));
                end
            end
            default: begin
                repeat (int'(wdats_q[k])) @(posedge clk_i);
            end
        endcase
    endtask

    initial begin
        int n_access;
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        cyc_i     = 1'b0;
        stb_i     = 1'b0;
        we_i      = 1'b0;
        adr_i     = '0;
        dat_i     = '0;
        sys_clk   = 1'b1;
        gtp_clk   = 1'b1;
        rx_clk    = 1'b1;
        rx_clk_x2 = 1'b0;
        clk200    = 1'b0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        load_stimulus(n_access);
        cycle_limit = n_access * 8 + 4 * hk_pkg::MON_GATE_CYCLES + 200;
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int k = 0; k < ops_q.size(); k++) begin
            run_operation(k);
        end
        repeat (4) @(posedge clk_i);
        if (u_hk_top.u_hk_assert.fail_count != 0) begin
            report_failure("handshake assertion failed near the end of the run");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: dv/hk_assert.sv
`timescale 1ns/1ps

// Wishbone handshake checks bound into hk_top
module hk_assert (
    input logic clk_i,
    input logic rst_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i
);

    // Number of handshake checks that have failed so far
    int fail_count = 0;

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i
    ) else begin
        fail_count++;
        $error("ack_o high for two cycles in a row");
    end

    // Every ack answers a strobe sampled three edges earlier
    ack_has_request: assert property (
        @(posedge clk_i) disable iff (rst_i) ack_i |-> $past(cyc_i && stb_i, 3)
    ) else begin
        fail_count++;
        $error("ack_o without a preceding request");
    end

    // Synchronous reset clears ack on the following edge
    ack_low_in_reset: assert property (
        @(posedge clk_i) rst_i |=> !ack_i
    ) else begin
        fail_count++;
        $error("ack_o high while reset is applied");
    end

endmodule

bind hk_top hk_assert u_hk_assert (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .ack_i (ack_o)
);

// File: logic/hk_top.sv
`timescale 1ns/1ps

// Housekeeping register block, three-stage Wishbone target
module hk_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      cyc_i,
    input  logic                      stb_i,
    input  logic                      we_i,
    input  logic [hk_pkg::ADR_W-1:0]  adr_i,
    input  hk_pkg::hk_word_t          dat_i,
    output logic                      ack_o,
    output hk_pkg::hk_word_t          dat_o,
    // Monitored clocks
    input  logic                      sys_clk_i,
    input  logic                      gtp_clk_i,
    input  logic                      rx_clk_i,
    input  logic                      rx_clk_x2_i,
    input  logic                      clk200_i,
    output logic [hk_pkg::CTRL_W-1:0] ctrl_o
);

    hk_req_if req ();

    logic id_rsp_valid;
    hk_pkg::hk_word_t id_rsp_dat;
    logic cm_rsp_valid;
    hk_pkg::hk_word_t cm_rsp_dat;
    logic [hk_pkg::NUM_CLOCKS-1:0] alive;

    // Stage 1
    hk_bus_decode u_decode (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cyc_i (cyc_i),
        .stb_i (stb_i),
        .we_i  (we_i),
        .adr_i (adr_i),
        .dat_i (dat_i),
        .ack_i (ack_o),
        .req   (req.src)
    );

    // Stage 2, internal and unmapped regions
    hk_id_regs u_id_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req         (req.dst),
        .alive_i     (alive),
        .rsp_valid_o (id_rsp_valid),
        .rsp_dat_o   (id_rsp_dat),
        .ctrl_o      (ctrl_o)
    );

    // Stage 2, clock monitors; channel 0 is the lowest address
    clock_mon u_clock_mon (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req         (req.dst),
        .clk_mon_i   ({clk200_i, rx_clk_x2_i, rx_clk_i, gtp_clk_i, sys_clk_i}),
        .rsp_valid_o (cm_rsp_valid),
        .rsp_dat_o   (cm_rsp_dat),
        .alive_o     (alive)
    );

    // Stage 3, at most one target answers per request
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= id_rsp_valid || cm_rsp_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cm_rsp_valid) begin
            dat_o <= cm_rsp_dat;
        end else if (id_rsp_valid) begin
            dat_o <= id_rsp_dat;
        end else begin
            dat_o <= '0;
        end
    end

endmodule

// File: logic/hk_id_regs.sv
`timescale 1ns/1ps

// Stage 2 target for ID, version, serial port and control/status
// Also answers the unmapped region so every access completes
module hk_id_regs (
    input  logic                          clk_i,
    input  logic                          rst_i,
    hk_req_if.dst                         req,
    input  logic [hk_pkg::NUM_CLOCKS-1:0] alive_i,
    output logic                          rsp_valid_o,
    output hk_pkg::hk_word_t              rsp_dat_o,
    output logic [hk_pkg::CTRL_W-1:0]     ctrl_o
);

    // Register slots, 0x010-0x03C alias through adr[3:2]
    localparam logic [1:0] SLOT_ID     = 2'd0;
    localparam logic [1:0] SLOT_VER    = 2'd1;
    localparam logic [1:0] SLOT_SERIAL = 2'd2;
    localparam logic [1:0] SLOT_CTRL   = 2'd3;

    logic [1:0] slot;
    logic hit_int;
    logic hit_unmapped;
    logic [hk_pkg::CTRL_W-1:0] ctrl_q;
    logic [hk_pkg::SERIAL_W-1:0] serial_q;
    hk_pkg::hk_word_t rd_word;

    assign slot         = req.adr[3:2];
    assign hit_int      = req.valid && (req.region == hk_pkg::HK_INTERNAL);
    assign hit_unmapped = req.valid && (req.region == hk_pkg::HK_UNMAPPED);

    // Read mux
    always_comb begin
        rd_word = '0;
        case (slot)
            SLOT_ID:     rd_word = hk_pkg::DEVICE_ID;
            SLOT_VER:    rd_word = hk_pkg::FW_VERSION;
            // Only the current serial bit is visible
            SLOT_SERIAL: rd_word[0] = serial_q[0];
            SLOT_CTRL: begin
                rd_word[hk_pkg::CTRL_W-1:0] = ctrl_q;
                rd_word[hk_pkg::ALIVE_LSB +: hk_pkg::NUM_CLOCKS] = alive_i;
            end
            default:     rd_word = '0;
        endcase
    end

    // Control register, written through any alias of 0x00C
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q <= '0;
        end else if (hit_int && req.we && (slot == SLOT_CTRL)) begin
            ctrl_q <= req.wdat[hk_pkg::CTRL_W-1:0];
        end
    end

    // Serial-ID shifter
    // Write with bit 31 reloads, each read moves to the next bit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            serial_q <= hk_pkg::SERIAL_ID;
        end else if (hit_int && (slot == SLOT_SERIAL)) begin
            if (req.we) begin
                if (req.wdat[31]) begin
                    serial_q <= hk_pkg::SERIAL_ID;
                end
            end else begin
                // Zeros fill in from the top once exhausted
                serial_q <= {1'b0, serial_q[hk_pkg::SERIAL_W-1:1]};
            end
        end
    end

    // Response handshake
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= hit_int || hit_unmapped;
        end
    end

    // Response data, writes and unmapped reads return zero
    always_ff @(posedge clk_i) begin
        if (hit_int && !req.we) begin
            rsp_dat_o <= rd_word;
        end else begin
            rsp_dat_o <= '0;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

// File: logic/hk_bus_decode.sv
`timescale 1ns/1ps

// Stage 1 captures the Wishbone request and picks the target region
module hk_bus_decode (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     cyc_i,
    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [hk_pkg::ADR_W-1:0] adr_i,
    input  hk_pkg::hk_word_t         dat_i,
    // Stage-3 acknowledge ends the outstanding request
    input  logic                     ack_i,
    hk_req_if.src                    req
);

    // Set while a request is in flight
    logic busy_q;
    logic accept;
    logic [hk_pkg::REGION_W-1:0] region_bits;
    hk_pkg::hk_region_e region_d;

    // Master holds stb until ack, so busy blocks a second capture
    assign accept = cyc_i && stb_i && !busy_q;

    assign region_bits = adr_i[hk_pkg::ADR_W-1 -: hk_pkg::REGION_W];

    always_comb begin
        if (region_bits == hk_pkg::REGION_INTERNAL) begin
            region_d = hk_pkg::HK_INTERNAL;
        end else if (region_bits == hk_pkg::REGION_CLOCKMON) begin
            region_d = hk_pkg::HK_CLOCKMON;
        end else begin
            // Unmapped region gets a zero answer from id_regs
            region_d = hk_pkg::HK_UNMAPPED;
        end
    end

    // Control path
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Request payload is only meaningful alongside valid
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req.we     <= we_i;
            req.adr    <= adr_i;
            req.wdat   <= dat_i;
            req.region <= region_d;
        end
    end

endmodule

// File: clock_mon/clock_mon.sv
`timescale 1ns/1ps

// Stage 2 target for the clock frequency monitors
module clock_mon (
    input  logic                          clk_i,
    input  logic                          rst_i,
    hk_req_if.dst                         req,
    input  logic [hk_pkg::NUM_CLOCKS-1:0] clk_mon_i,
    output logic                          rsp_valid_o,
    output hk_pkg::hk_word_t              rsp_dat_o,
    output logic [hk_pkg::NUM_CLOCKS-1:0] alive_o
);

    logic [hk_pkg::MON_GATE_W-1:0] gate_q;
    logic gate_end;
    // Synchronized running counts, one per channel
    logic [hk_pkg::MON_CNT_W-1:0] count_w [hk_pkg::NUM_CLOCKS];
    // Count seen at the previous window end
    logic [hk_pkg::MON_CNT_W-1:0] prev_q [hk_pkg::NUM_CLOCKS];
    logic [hk_pkg::MON_CNT_W-1:0] delta [hk_pkg::NUM_CLOCKS];
    logic [hk_pkg::MON_CNT_W-1:0] result_q [hk_pkg::NUM_CLOCKS];
    logic [hk_pkg::MON_IDX_W-1:0] idx;
    logic hit;
    hk_pkg::hk_word_t rd_word;

    for (genvar i = 0; i < hk_pkg::NUM_CLOCKS; i++) begin : g_cell
        clock_count_cell u_cell (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .mon_clk_i (clk_mon_i[i]),
            .count_o   (count_w[i])
        );
    end

    // Gate timer, wraps at the window length
    assign gate_end = (gate_q == hk_pkg::MON_GATE_W'(hk_pkg::MON_GATE_CYCLES - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gate_q <= '0;
        end else begin
            gate_q <= gate_q + 1'b1;
        end
    end

    // Edges this window, modulo counter width
    always_comb begin
        for (int i = 0; i < hk_pkg::NUM_CLOCKS; i++) begin
            delta[i] = count_w[i] - prev_q[i];
        end
    end

    // Latch per-channel results at each window end
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < hk_pkg::NUM_CLOCKS; i++) begin
                prev_q[i]   <= '0;
                result_q[i] <= '0;
                alive_o[i]  <= 1'b0;
            end
        end else if (gate_end) begin
            for (int i = 0; i < hk_pkg::NUM_CLOCKS; i++) begin
                prev_q[i]   <= count_w[i];
                result_q[i] <= delta[i];
                alive_o[i]  <= (delta[i] != '0);
            end
        end
    end

    // Bus side, channel from adr[4:2]
    assign hit = req.valid && (req.region == hk_pkg::HK_CLOCKMON);
    assign idx = req.adr[2 +: hk_pkg::MON_IDX_W];

    always_comb begin
        rd_word = '0;
        // Indexes past the last channel read zero
        if (!req.we && (int'(idx) < hk_pkg::NUM_CLOCKS)) begin
            rd_word[hk_pkg::MON_CNT_W-1:0] = result_q[idx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= hit;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_dat_o <= rd_word;
    end

endmodule

// File: clock_mon/clock_count_cell.sv
`timescale 1ns/1ps

// Edge counter in the monitored domain, seen from clk_i via Gray code
module clock_count_cell (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         mon_clk_i,
    output logic [hk_pkg::MON_CNT_W-1:0] count_o
);

    // Reset carried into the monitored domain
    logic [1:0] mon_rst_q;
    logic [hk_pkg::MON_CNT_W-1:0] bin_q;
    // Registered so only one bit moves per monitored edge
    logic [hk_pkg::MON_CNT_W-1:0] gray_q;
    // Two-flop synchronizer into clk_i
    logic [hk_pkg::MON_CNT_W-1:0] sync1_q;
    logic [hk_pkg::MON_CNT_W-1:0] sync2_q;

    always_ff @(posedge mon_clk_i) begin
        mon_rst_q <= {mon_rst_q[0], rst_i};
    end

    // Free-running counter and Gray encode
    always_ff @(posedge mon_clk_i) begin
        if (mon_rst_q[1]) begin
            bin_q  <= '0;
            gray_q <= '0;
        end else begin
            bin_q  <= bin_q + 1'b1;
            gray_q <= bin_q ^ (bin_q >> 1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gray_q;
            sync2_q <= sync1_q;
        end
    end

    // Gray back to binary, MSB down
    always_comb begin
        count_o[hk_pkg::MON_CNT_W-1] = sync2_q[hk_pkg::MON_CNT_W-1];
        for (int i = hk_pkg::MON_CNT_W - 2; i >= 0; i--) begin
            count_o[i] = count_o[i+1] ^ sync2_q[i];
        end
    end

endmodule

// File: common/hk_req_if.sv
`timescale 1ns/1ps

// Decoded request from stage 1 to both stage-2 targets
interface hk_req_if;

    // One-cycle pulse per accepted bus request
    logic valid;
    logic we;
    logic [hk_pkg::ADR_W-1:0] adr;
    hk_pkg::hk_word_t wdat;
    hk_pkg::hk_region_e region;

    // Decode stage drives everything
    modport src (
        output valid,
        output we,
        output adr,
        output wdat,
        output region
    );

    // Targets only look
    modport dst (
        input valid,
        input we,
        input adr,
        input wdat,
        input region
    );

endinterface

// File: common/hk_pkg.sv
package hk_pkg;

    // Bus geometry
    localparam int ADR_W = 12;
    localparam int DAT_W = 32;

    // Upper address bits select a 64-byte region
    localparam int REGION_W = 6;
    localparam logic [REGION_W-1:0] REGION_INTERNAL = 6'd0;
    localparam logic [REGION_W-1:0] REGION_CLOCKMON = 6'd1;

    // One bus data word
    typedef logic [DAT_W-1:0] hk_word_t;

    // Decoded target of a request
    typedef enum logic [1:0] {
        HK_INTERNAL = 2'd0,
        HK_CLOCKMON = 2'd1,
        HK_UNMAPPED = 2'd2
    } hk_region_e;

    // ASCII "HKIO"
    localparam hk_word_t DEVICE_ID = 32'h484B_494F;

    // Packed as major / minor / revision / build
    localparam hk_word_t FW_VERSION = {8'd1, 8'd4, 8'd2, 8'd17};

    // Modelled serial number, shifted out LSB first
    localparam int SERIAL_W = 64;
    localparam logic [SERIAL_W-1:0] SERIAL_ID = 64'h5A3C_0F96_1E2D_4B87;

    // Width of the read/write control field at 0x00C
    localparam int CTRL_W = 16;

    // Clock monitor channels
    // 0 sys, 1 gtp, 2 rx, 3 rx x2, 4 clk200
    localparam int NUM_CLOCKS = 5;
    localparam int MON_IDX_W = 3;

    // Gate window length in clk_i cycles
    localparam int MON_GATE_CYCLES = 256;
    localparam int MON_GATE_W = $clog2(MON_GATE_CYCLES);

    // Edge counter width; wraps harmlessly since only differences are used
    localparam int MON_CNT_W = 16;

    // Bit position of the alive flags inside the control/status word
    localparam int ALIVE_LSB = 16;

endpackage
